//--- capture_defines.svh
`ifndef CAPTURE_DEFINES_SVH
`define CAPTURE_DEFINES_SVH

// host bus
`define ADDR_W       8
`define DATA_W       8

// capture path
`define SAMPLE_W     8
`define FIFO_DEPTH   16
`define COUNT_W      5    // holds 0 .. FIFO_DEPTH

// error LED pacing, bit 3 of the free counter gives a 16 cycle period
`define FLASH_BIT    3

// register map
`define ADDR_CTRL    8'h01
`define ADDR_CMD     8'h02
`define ADDR_STATUS  8'h03
`define ADDR_COUNT   8'h04
`define ADDR_FIFO    8'h10

`endif

//--- capture_pkg.sv
`include "capture_defines.svh"

package capture_pkg;

   // one register stroke from the bus decoder
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
      logic               rd;      // read stroke, one cycle
      logic               wr;      // write stroke, one cycle
   } reg_bus_t;

   typedef struct packed {
      logic                 valid;
      logic [`SAMPLE_W-1:0] data;
   } sample_t;

   // control from the register block to the FIFO
   typedef struct packed {
      logic source_sel;    // 0 trace, 1 LA
      logic flush;
      logic clear_errors;
   } fifo_ctrl_t;

   typedef struct packed {
      logic                empty;
      logic                full;
      logic                error;   // sticky overflow
      logic [`COUNT_W-1:0] count;
   } fifo_stat_t;

   // value and enable pairs for the target pins
   typedef struct packed {
      logic poweron;
      logic nrst_o;
      logic nrst_oe;
      logic mosi_o;
      logic mosi_oe;
      logic sck_o;
      logic sck_oe;
   } target_pins_t;

endpackage

//--- usb_reg_decode.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module usb_reg_decode import capture_pkg::*; (
   input  logic               clk_usb_buf,
   input  logic               rst_n_i,
   input  logic               usb_cen_n_i,
   input  logic               usb_rdn_i,
   input  logic               usb_wrn_i,
   input  logic [`ADDR_W-1:0] usb_addr_i,
   input  logic [`DATA_W-1:0] usb_data_i,
   output reg_bus_t           reg_bus_o
);

   logic               cen_q, rdn_q, wrn_q;   // pins, registered once
   logic               rdn_d, wrn_d;          // previous strobe level
   logic [`ADDR_W-1:0] addr_q;
   logic [`DATA_W-1:0] data_q;
   logic               rd_fall, wr_fall;
   logic               rd_pulse, wr_pulse;
   logic [`ADDR_W-1:0] cap_addr;
   logic [`DATA_W-1:0] cap_data;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cen_q <= 1'b1;
         rdn_q <= 1'b1;
         wrn_q <= 1'b1;
         rdn_d <= 1'b1;
         wrn_d <= 1'b1;
      end else begin
         cen_q <= usb_cen_n_i;
         rdn_q <= usb_rdn_i;
         wrn_q <= usb_wrn_i;
         rdn_d <= rdn_q;
         wrn_d <= wrn_q;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      addr_q <= usb_addr_i;
      data_q <= usb_data_i;
   end

   // falling strobe inside a chip-enabled cycle
   assign rd_fall = !cen_q && !rdn_q && rdn_d;
   assign wr_fall = !cen_q && !wrn_q && wrn_d;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_pulse <= 1'b0;
         wr_pulse <= 1'b0;
      end else begin
         rd_pulse <= rd_fall;
         wr_pulse <= wr_fall;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      cap_addr <= addr_q;   // stable for the whole strobe
      cap_data <= data_q;
   end

   // stroke lands two cycles after the strobe is first seen low
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_bus_o <= '0;
      end else begin
         reg_bus_o.addr  <= cap_addr;
         reg_bus_o.wdata <= cap_data;
         reg_bus_o.rd    <= rd_pulse;
         reg_bus_o.wr    <= wr_pulse;
      end
   end

endmodule

//--- ctrl_regs.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module ctrl_regs import capture_pkg::*; (
   input  logic               clk_usb_buf,
   input  logic               rst_n_i,
   input  reg_bus_t           reg_bus_i,
   input  fifo_stat_t         fifo_stat_i,
   input  logic               pll_status_i,
   input  logic               avr_rst_i,
   input  logic               sam_mosi_i,
   input  logic               sam_sck_i,
   output fifo_ctrl_t         fifo_ctrl_o,
   output logic [`DATA_W-1:0] rdata_o,
   output target_pins_t       pins_o,
   output logic               led_error_o
);

   logic [4:0]          ctrl_q;
   logic                power_off, avrprog_en, nrst_oe, nrst_val, source_sel;
   logic                cmd_wr;
   logic                flush_q, clear_q;
   logic [`FLASH_BIT:0] flash_cnt;
   logic                flash;

   assign power_off  = ctrl_q[0];
   assign avrprog_en = ctrl_q[1];
   assign nrst_oe    = ctrl_q[2];
   assign nrst_val   = ctrl_q[3];
   assign source_sel = ctrl_q[4];

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= 5'b00001;   // target power starts off
      end else if (reg_bus_i.wr && reg_bus_i.addr == `ADDR_CTRL) begin
         ctrl_q <= reg_bus_i.wdata[4:0];
      end
   end

   assign cmd_wr = reg_bus_i.wr && reg_bus_i.addr == `ADDR_CMD;

   // CMD bits are self-clearing, one cycle after the stroke
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flush_q <= 1'b0;
         clear_q <= 1'b0;
      end else begin
         flush_q <= cmd_wr && reg_bus_i.wdata[0];
         clear_q <= cmd_wr && reg_bus_i.wdata[1];
      end
   end

   assign fifo_ctrl_o.source_sel   = source_sel;
   assign fifo_ctrl_o.flush        = flush_q;
   assign fifo_ctrl_o.clear_errors = clear_q;

   always_comb begin
      case (reg_bus_i.addr)
         `ADDR_CTRL:   rdata_o = {3'b000, ctrl_q};
         `ADDR_STATUS: rdata_o = {5'b00000, fifo_stat_i.error, fifo_stat_i.full,
                                  fifo_stat_i.empty};
         `ADDR_COUNT:  rdata_o = {{(`DATA_W-`COUNT_W){1'b0}}, fifo_stat_i.count};
         default:      rdata_o = '0;   // includes the FIFO address
      endcase
   end

   always_comb begin
      pins_o         = '0;
      pins_o.poweron = !power_off;
      if (!power_off) begin
         if (avrprog_en) begin
            // host programming lines straight through
            pins_o.nrst_o  = avr_rst_i;
            pins_o.nrst_oe = 1'b1;
            pins_o.mosi_o  = sam_mosi_i;
            pins_o.mosi_oe = 1'b1;
            pins_o.sck_o   = sam_sck_i;
            pins_o.sck_oe  = 1'b1;
         end else begin
            pins_o.nrst_o  = nrst_val;
            pins_o.nrst_oe = nrst_oe;
         end
      end
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flash_cnt <= '0;
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
      end
   end

   assign flash       = flash_cnt[`FLASH_BIT];
   assign led_error_o = fifo_stat_i.error ? flash : !pll_status_i;   // PLL lock is active high

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module sample_fifo import capture_pkg::*; (
   input  logic                 clk_usb_buf,
   input  logic                 rst_n_i,
   input  reg_bus_t             reg_bus_i,
   input  fifo_ctrl_t           fifo_ctrl_i,
   input  sample_t              trace_sample_i,
   input  sample_t              la_sample_i,
   output fifo_stat_t           fifo_stat_o,
   output logic [`SAMPLE_W-1:0] head_o
);

   localparam int PTR_W = $clog2(`FIFO_DEPTH);

   logic [`SAMPLE_W-1:0] mem [`FIFO_DEPTH];
   logic [PTR_W-1:0]     wptr, rptr;
   logic [`COUNT_W-1:0]  count;
   logic                 error_q;
   sample_t              src;
   logic                 empty, full;
   logic                 push, pop;

   // only the selected source reaches the FIFO
   assign src   = fifo_ctrl_i.source_sel ? la_sample_i : trace_sample_i;
   assign empty = count == '0;
   assign full  = count == `COUNT_W'(`FIFO_DEPTH);

   assign push = src.valid && !full;   // never stalls, drops when full
   assign pop  = reg_bus_i.rd && reg_bus_i.addr == `ADDR_FIFO && !empty;

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem[wptr] <= src.data;
      end
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else if (fifo_ctrl_i.flush) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wptr <= wptr + 1'b1;
         end
         if (pop) begin
            rptr <= rptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // sticky overflow, survives a flush
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         error_q <= 1'b0;
      end else if (src.valid && full) begin
         error_q <= 1'b1;
      end else if (fifo_ctrl_i.clear_errors) begin
         error_q <= 1'b0;
      end
   end

   assign head_o = empty ? '0 : mem[rptr];

   assign fifo_stat_o.empty = empty;
   assign fifo_stat_o.full  = full;
   assign fifo_stat_o.error = error_q;
   assign fifo_stat_o.count = count;

endmodule

//--- read_result.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module read_result import capture_pkg::*; (
   input  logic                 clk_usb_buf,
   input  logic                 rst_n_i,
   input  reg_bus_t             reg_bus_i,
   input  logic [`DATA_W-1:0]   rdata_i,
   input  logic [`SAMPLE_W-1:0] head_i,
   output logic [`DATA_W-1:0]   usb_data_o
);

   logic fifo_sel;

   // register block returns zero when not addressed
   assign fifo_sel = reg_bus_i.addr == `ADDR_FIFO;

   // held on the bus until the next read stroke
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         usb_data_o <= '0;
      end else if (reg_bus_i.rd) begin
         usb_data_o <= fifo_sel ? head_i : rdata_i;   // FIFO head bypasses the register data
      end
   end

endmodule

//--- capture_top.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_top (
   input  logic                    clk_usb_buf,
   input  logic                    rst_n_i,
   input  logic                    usb_cen_n_i,
   input  logic                    usb_rdn_i,
   input  logic                    usb_wrn_i,
   input  logic [`ADDR_W-1:0]      usb_addr_i,
   input  logic [`DATA_W-1:0]      usb_data_i,
   output logic [`DATA_W-1:0]      usb_data_o,
   input  logic                    pll_status_i,
   input  logic                    avr_rst_i,
   input  logic                    sam_mosi_i,
   input  logic                    sam_sck_i,
   input  capture_pkg::sample_t    trace_sample_i,
   input  capture_pkg::sample_t    la_sample_i,
   output capture_pkg::target_pins_t pins_o,
   output logic                    led_error_o
);

   capture_pkg::reg_bus_t   reg_bus;
   capture_pkg::fifo_ctrl_t fifo_ctrl;
   capture_pkg::fifo_stat_t fifo_stat;
   logic [`DATA_W-1:0]      rdata;
   logic [`SAMPLE_W-1:0]    fifo_head;

   usb_reg_decode u_decode (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .usb_cen_n_i (usb_cen_n_i),
      .usb_rdn_i   (usb_rdn_i),
      .usb_wrn_i   (usb_wrn_i),
      .usb_addr_i  (usb_addr_i),
      .usb_data_i  (usb_data_i),
      .reg_bus_o   (reg_bus)
   );

   ctrl_regs u_ctrl_regs (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .reg_bus_i    (reg_bus),
      .fifo_stat_i  (fifo_stat),
      .pll_status_i (pll_status_i),
      .avr_rst_i    (avr_rst_i),
      .sam_mosi_i   (sam_mosi_i),
      .sam_sck_i    (sam_sck_i),
      .fifo_ctrl_o  (fifo_ctrl),
      .rdata_o      (rdata),
      .pins_o       (pins_o),
      .led_error_o  (led_error_o)
   );

   sample_fifo u_sample_fifo (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_bus_i      (reg_bus),
      .fifo_ctrl_i    (fifo_ctrl),
      .trace_sample_i (trace_sample_i),
      .la_sample_i    (la_sample_i),
      .fifo_stat_o    (fifo_stat),
      .head_o         (fifo_head)
   );

   read_result u_read_result (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .reg_bus_i   (reg_bus),
      .rdata_i     (rdata),
      .head_i      (fifo_head),
      .usb_data_o  (usb_data_o)
   );

endmodule

//--- capture_checker.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_checker import capture_pkg::*; (
   input logic         clk_usb_buf,
   input logic         rst_n_i,
   input reg_bus_t     reg_bus_i,
   input fifo_stat_t   fifo_stat_i,
   input logic         pll_status_i,
   input logic         avr_rst_i,
   input logic         sam_mosi_i,
   input logic         sam_sck_i,
   input target_pins_t pins_i,
   input logic         led_error_i
);

   int unsigned fail_cnt = 0;
   logic [4:0]  ctrl_shadow;   // CTRL rebuilt from the write strokes

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_shadow <= 5'b00001;
      end else if (reg_bus_i.wr && reg_bus_i.addr == `ADDR_CTRL) begin
         ctrl_shadow <= reg_bus_i.wdata[4:0];
      end
   end

   power_off_pins: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      ctrl_shadow[0] |-> pins_i == 7'b0)
   else begin
      fail_cnt++;
      $error("target pins driven while target power is off");
   end

   avrprog_pins: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !ctrl_shadow[0] && ctrl_shadow[1] |->
         pins_i == {1'b1, avr_rst_i, 1'b1, sam_mosi_i, 1'b1, sam_sck_i, 1'b1})
   else begin
      fail_cnt++;
      $error("programming lines not passed through");
   end

   manual_pins: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !ctrl_shadow[0] && !ctrl_shadow[1] |->
         pins_i == {1'b1, ctrl_shadow[3], ctrl_shadow[2], 4'b0000})
   else begin
      fail_cnt++;
      $error("nrst drive does not follow CTRL");
   end

   led_pll: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !fifo_stat_i.error |-> led_error_i == !pll_status_i)
   else begin
      fail_cnt++;
      $error("error LED does not follow the PLL status");
   end

   // strokes last exactly one cycle
   rd_stroke_width: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      reg_bus_i.rd |=> !reg_bus_i.rd)
   else begin
      fail_cnt++;
      $error("read stroke longer than one cycle");
   end

   wr_stroke_width: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      reg_bus_i.wr |=> !reg_bus_i.wr)
   else begin
      fail_cnt++;
      $error("write stroke longer than one cycle");
   end

   count_bound: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      fifo_stat_i.count <= `COUNT_W'(`FIFO_DEPTH))
   else begin
      fail_cnt++;
      $error("FIFO count above depth");
   end

endmodule

bind capture_top capture_checker u_checker (
   .clk_usb_buf  (clk_usb_buf),
   .rst_n_i      (rst_n_i),
   .reg_bus_i    (reg_bus),
   .fifo_stat_i  (fifo_stat),
   .pll_status_i (pll_status_i),
   .avr_rst_i    (avr_rst_i),
   .sam_mosi_i   (sam_mosi_i),
   .sam_sck_i    (sam_sck_i),
   .pins_i       (pins_o),
   .led_error_i  (led_error_o)
);

//--- capture_tb.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_tb import capture_pkg::*; ();

   localparam int MAX_CYCLES = 4000;   // all tests need roughly 1000 cycles

   logic               clk_usb_buf = 1'b0;
   logic               rst_n;
   logic               usb_cen_n, usb_rdn, usb_wrn;
   logic [`ADDR_W-1:0] usb_addr;
   logic [`DATA_W-1:0] usb_wdata;
   logic [`DATA_W-1:0] usb_rdata;
   logic               pll_status, avr_rst, sam_mosi, sam_sck;
   sample_t            trace_sample, la_sample;
   target_pins_t       pins;
   logic               led_error;
   logic [15:0]        lfsr_q = 16'd35322;
   logic [7:0]         expect_q[$];   // samples the FIFO should hold, oldest first
   int                 cycle_cnt = 0;

   capture_top dut (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n),
      .usb_cen_n_i    (usb_cen_n),
      .usb_rdn_i      (usb_rdn),
      .usb_wrn_i      (usb_wrn),
      .usb_addr_i     (usb_addr),
      .usb_data_i     (usb_wdata),
      .usb_data_o     (usb_rdata),
      .pll_status_i   (pll_status),
      .avr_rst_i      (avr_rst),
      .sam_mosi_i     (sam_mosi),
      .sam_sck_i      (sam_sck),
      .trace_sample_i (trace_sample),
      .la_sample_i    (la_sample),
      .pins_o         (pins),
      .led_error_o    (led_error)
   );

   always #2 clk_usb_buf = ~clk_usb_buf;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   always @(posedge clk_usb_buf) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         stop_with_failure("timeout, the tests did not finish within the cycle limit");
      end
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      repeat (n) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[6:0], lfsr_q[0]};
      end
   endtask

   // inputs change 1 ns after the rising edge
   task automatic step(input int n);
      repeat (n) @(posedge clk_usb_buf);
      #1;
   endtask

   task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      assert (got === exp)
      else begin
         stop_with_failure($sformatf("** Error %s: expected 0x%02h, actual 0x%02h",
                                     name, exp, got));
      end
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      usb_cen_n = 1'b0;
      usb_addr  = addr;
      usb_wdata = data;
      step(1);
      usb_wrn = 1'b0;
      step(4);
      usb_wrn = 1'b1;
      step(2);
      usb_cen_n = 1'b1;
      step(1);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      usb_cen_n = 1'b0;
      usb_addr  = addr;
      step(1);
      usb_rdn = 1'b0;
      step(4);
      usb_rdn = 1'b1;
      step(2);
      data      = usb_rdata;   // held until the next read
      usb_cen_n = 1'b1;
      step(1);
   endtask

   task automatic read_check(input string name, input logic [7:0] addr, input logic [7:0] exp);
      logic [7:0] got;
      bus_read(addr, got);
      check_value(name, exp, got);
   endtask

   // selected source carries the sample, the other one a decoy
   task automatic send_samples(input logic la_sel, input int n);
      logic [7:0] d;
      logic [7:0] gap;
      for (int i = 0; i < n; i++) begin
         take_bits(8, d);
         take_bits(2, gap);
         trace_sample = la_sel ? {1'b1, ~d} : {1'b1, d};
         la_sample    = la_sel ? {1'b1, d} : {1'b1, ~d};
         if (expect_q.size() < `FIFO_DEPTH) begin
            expect_q.push_back(d);   // dropped once full
         end
         step(1);
         trace_sample = '0;
         la_sample    = '0;
         step(int'(gap) + 1);
      end
   endtask

   task automatic drain_check(input string name);
      while (expect_q.size() > 0) begin
         read_check(name, `ADDR_FIFO, expect_q.pop_front());
      end
   endtask

   initial begin
      logic [7:0] r;
      logic       seen_low, seen_high;
      rst_n        = 1'b0;
      usb_cen_n    = 1'b1;
      usb_rdn      = 1'b1;
      usb_wrn      = 1'b1;
      usb_addr     = '0;
      usb_wdata    = '0;
      pll_status   = 1'b1;
      avr_rst      = 1'b0;
      sam_mosi     = 1'b0;
      sam_sck      = 1'b0;
      trace_sample = '0;
      la_sample    = '0;
      repeat (4) @(posedge clk_usb_buf);
      #1 rst_n = 1'b1;
      step(2);

      // reset values
      read_check("reset ctrl", `ADDR_CTRL, 8'h01);
      read_check("reset status", `ADDR_STATUS, 8'h01);
      check_value("reset pins", 8'h00, {1'b0, pins});
      bus_write(`ADDR_CTRL, 8'h1f);
      read_check("ctrl readback", `ADDR_CTRL, 8'h1f);
      bus_write(`ADDR_CTRL, 8'h0a);
      read_check("ctrl readback", `ADDR_CTRL, 8'h0a);

      // pin rules, order is poweron nrst nrst_oe mosi mosi_oe sck sck_oe
      bus_write(`ADDR_CTRL, 8'h0c);
      check_value("nrst drive high", 8'h70, {1'b0, pins});
      bus_write(`ADDR_CTRL, 8'h04);
      check_value("nrst drive low", 8'h50, {1'b0, pins});
      bus_write(`ADDR_CTRL, 8'h02);
      repeat (6) begin
         take_bits(3, r);
         avr_rst  = r[2];
         sam_mosi = r[1];
         sam_sck  = r[0];
         step(1);
         check_value("avr passthrough", {2'b01, r[2], 1'b1, r[1], 1'b1, r[0], 1'b1},
                     {1'b0, pins});
      end
      bus_write(`ADDR_CTRL, 8'h03);
      check_value("power off", 8'h00, {1'b0, pins});

      // source selection, trace then LA
      bus_write(`ADDR_CTRL, 8'h01);
      send_samples(1'b0, 6);
      read_check("trace count", `ADDR_COUNT, 8'd6);
      drain_check("trace order");
      bus_write(`ADDR_CTRL, 8'h11);
      send_samples(1'b1, 6);
      read_check("la count", `ADDR_COUNT, 8'd6);
      drain_check("la order");

      // overflow
      bus_write(`ADDR_CTRL, 8'h01);
      send_samples(1'b0, 20);
      read_check("overflow status", `ADDR_STATUS, 8'h06);
      seen_low  = 1'b0;
      seen_high = 1'b0;
      repeat (32) begin
         step(1);
         if (led_error) begin
            seen_high = 1'b1;
         end else begin
            seen_low = 1'b1;
         end
      end
      assert (seen_low && seen_high)
      else stop_with_failure("error LED did not flash while the overflow error was set");
      drain_check("overflow order");
      read_check("drained status", `ADDR_STATUS, 8'h05);
      bus_write(`ADDR_CMD, 8'h02);
      read_check("cleared status", `ADDR_STATUS, 8'h01);
      check_value("led pll locked", 8'h00, {7'b0, led_error});
      pll_status = 1'b0;
      step(1);
      check_value("led pll unlocked", 8'h01, {7'b0, led_error});

      // flush and empty reads
      send_samples(1'b0, 5);
      read_check("pre flush count", `ADDR_COUNT, 8'd5);
      bus_write(`ADDR_CMD, 8'h01);
      expect_q.delete();
      read_check("flush count", `ADDR_COUNT, 8'd0);
      read_check("flush status", `ADDR_STATUS, 8'h01);
      read_check("empty read", `ADDR_FIFO, 8'h00);
      step(4);

      if (dut.u_checker.fail_cnt == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         stop_with_failure("bound checker assertions failed");
      end
   end

endmodule

//--- sim.f
+incdir+.
capture_pkg.sv
usb_reg_decode.sv
ctrl_regs.sv
sample_fifo.sv
read_result.sv
capture_top.sv
capture_checker.sv
capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module capture_tb -f sim.f -o capture_sim \
   && ./obj_dir/capture_sim | tee /dev/stderr | grep "Simulation passed" > /dev/null \
   && { echo "run_sim: PASS"; exit 0; } \
   || { echo "run_sim: FAIL"; exit 1; }
